/* all.f */
hdl/ttc_pkg.sv
hdl/ttc_cmd_decoder.sv
hdl/bx_counter.sv
hdl/fmm.sv
hdl/trigger_gate.sv
hdl/apb_ctrl_regs.sv
hdl/ttc_control_top.sv
test/ttc_control_asserts.sv
test/tb_ttc_control.sv

/* hdl/apb_ctrl_regs.sv */
// Zero-wait APB slave, every access completes in its enable cycle
// Erroring writes leave all registers unchanged
`timescale 1ns/100ps

module apb_ctrl_regs (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  ttc_pkg::apb_addr_t   paddr,
  input  ttc_pkg::apb_data_t   pwdata,
  output ttc_pkg::apb_data_t   prdata,
  output logic                 pslverr,
  input  logic                 sync_err,
  input  logic                 fmm_trig_stop,
  input  ttc_pkg::fmm_state_t  fmm_state,
  input  ttc_pkg::bxn_t        bxn,
  input  ttc_pkg::bxn_t        last_bxn,
  input  ttc_pkg::trig_count_t trig_acc,
  input  ttc_pkg::trig_count_t trig_drop,
  output logic                 ignore_startstop,
  output logic                 force_stop_trigger,
  output logic                 dont_wait,
  output logic                 clear_sync_err,
  output ttc_pkg::bxn_t        bxn_preset
);

  import ttc_pkg::*;

  logic access;
  logic addr_mapped;
  logic addr_writable;
  logic wr_en;

  // --------------------
  // Address decode
  // --------------------

  // Transfer cycle of the APB handshake
  assign access = psel && penable;

  always_comb begin
    case (paddr)
      ADDR_CTRL, ADDR_PRESET: begin
        addr_mapped   = 1'b1;
        addr_writable = 1'b1;
      end
      ADDR_STATUS, ADDR_BXN, ADDR_TRIG_ACC, ADDR_TRIG_DROP, ADDR_LAST_BXN: begin
        addr_mapped   = 1'b1;
        addr_writable = 1'b0;
      end
      default: begin
        addr_mapped   = 1'b0;
        addr_writable = 1'b0;
      end
    endcase
  end

  // Unmapped access, or write to a status register
  assign pslverr = access && (!addr_mapped || (pwrite && !addr_writable));
  assign wr_en   = access && pwrite && addr_writable;

  // --------------------
  // Writable registers
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      ignore_startstop   <= 1'b0;
      force_stop_trigger <= 1'b0;
      dont_wait          <= 1'b0;
      bxn_preset         <= BXN_PRESET_RESET;
    end else if (wr_en) begin
      if (paddr == ADDR_CTRL) begin
        ignore_startstop   <= pwdata[0];
        force_stop_trigger <= pwdata[1];
        dont_wait          <= pwdata[2];
      end
      if (paddr == ADDR_PRESET) begin
        bxn_preset <= pwdata[BXN_W-1:0];
      end
    end
  end

  // Self-clearing bit 3, acts at the end of the write cycle
  assign clear_sync_err = wr_en && (paddr == ADDR_CTRL) && pwdata[3];

  // --------------------
  // Read mux
  // --------------------

  always_comb begin
    case (paddr)
      ADDR_CTRL:      prdata = {29'd0, dont_wait, force_stop_trigger, ignore_startstop};
      ADDR_PRESET:    prdata = apb_data_t'(bxn_preset);
      ADDR_STATUS:    prdata = {25'd0, fmm_state, 2'd0, fmm_trig_stop, sync_err};
      ADDR_BXN:       prdata = apb_data_t'(bxn);
      ADDR_TRIG_ACC:  prdata = apb_data_t'(trig_acc);
      ADDR_TRIG_DROP: prdata = apb_data_t'(trig_drop);
      ADDR_LAST_BXN:  prdata = apb_data_t'(last_bxn);
      default:        prdata = '0;
    endcase
  end

endmodule

/* hdl/bx_counter.sv */
// Counts 0..BX_MAX every clock, loads the preset on resync
// Sync error is sticky until cleared through the register block
`timescale 1ns/100ps

module bx_counter (
  input  logic          clock,
  input  logic          reset,
  input  logic          bx0,
  input  logic          resync,
  input  logic          clear_sync_err,
  input  ttc_pkg::bxn_t bxn_preset,
  output ttc_pkg::bxn_t bxn,
  output logic          sync_err
);

  import ttc_pkg::*;

  bxn_t bxn_next;
  logic at_wrap;
  logic bx0_misaligned;

  // --------------------
  // Orbit counter
  // --------------------

  assign at_wrap = (bxn == BX_MAX);

  // Resync takes priority over counting
  always_comb begin
    if (resync) begin
      bxn_next = bxn_preset;
    end else if (at_wrap) begin
      bxn_next = '0;
    end else begin
      bxn_next = bxn + bxn_t'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      bxn <= '0;
    end else begin
      bxn <= bxn_next;
    end
  end

  // --------------------
  // Alignment check
  // --------------------

  // bx0 must land exactly on the preset count
  assign bx0_misaligned = bx0 && (bxn != bxn_preset);

  // Clear beats a new error in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      sync_err <= 1'b0;
    end else if (clear_sync_err) begin
      sync_err <= 1'b0;
    end else if (bx0_misaligned) begin
      sync_err <= 1'b1;
    end
  end

endmodule

/* hdl/fmm.sv */
// Trigger stop follows the state with one extra register stage
// Startup always passes through stop before any trigger is allowed
`timescale 1ns/100ps

module fmm (
  input  logic                clock,
  input  logic                reset,
  input  logic                bx0,
  input  logic                resync,
  input  logic                ignore_startstop,
  input  logic                force_stop_trigger,
  input  logic                dont_wait,
  output logic                fmm_trig_stop,
  output ttc_pkg::fmm_state_t fmm_state
);

  import ttc_pkg::*;

  fmm_state_t state;
  fmm_state_t state_next;
  logic       stop_req;

  // Force stop only counts when start/stop is not ignored
  assign stop_req = force_stop_trigger && !ignore_startstop;

  // --------------------
  // Next state
  // --------------------

  always_comb begin
    state_next = state;
    if (resync) begin
      // Resync overrides every state
      state_next = fmm_resync;
    end else begin
      case (state)
        fmm_startup: begin
          state_next = fmm_stop;
        end
        fmm_resync: begin
          // bx0 right behind the resync goes straight to run
          if (bx0) begin
            state_next = fmm_run;
          end else begin
            state_next = fmm_wait_bx0;
          end
        end
        fmm_stop: begin
          if (!stop_req) begin
            state_next = fmm_wait_bx0;
          end
        end
        fmm_wait_bx0: begin
          if (bx0 || dont_wait) begin
            state_next = fmm_run;
          end else if (stop_req) begin
            state_next = fmm_stop;
          end
        end
        fmm_run: begin
          if (stop_req) begin
            state_next = fmm_stop;
          end
        end
        // Unused codes recover to stop
        default: begin
          state_next = fmm_stop;
        end
      endcase
    end
  end

  // --------------------
  // State and stop flag
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= fmm_startup;
      fmm_trig_stop <= 1'b1;
    end else begin
      state         <= state_next;
      // Lags the state by one cycle
      fmm_trig_stop <= (state != fmm_run);
    end
  end

  assign fmm_state = state;

endmodule

/* hdl/trigger_gate.sv */
// Triggers are single-cycle strobes, a vetoed one is dropped and only counted
// Counters wrap at 16 bits with no overflow flag
`timescale 1ns/100ps

module trigger_gate (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 trig_in,
  input  logic                 fmm_trig_stop,
  input  ttc_pkg::bxn_t        bxn,
  output logic                 trig_out,
  output ttc_pkg::trig_count_t trig_acc,
  output ttc_pkg::trig_count_t trig_drop,
  output ttc_pkg::bxn_t        last_bxn
);

  import ttc_pkg::*;

  logic accept;
  logic veto;

  // Decision uses the stop flag of the trigger cycle
  assign accept = trig_in && !fmm_trig_stop;
  assign veto   = trig_in && fmm_trig_stop;

  // --------------------
  // Pass stage and counters
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      trig_out  <= 1'b0;
      trig_acc  <= '0;
      trig_drop <= '0;
      last_bxn  <= '0;
    end else begin
      trig_out <= accept;
      if (accept) begin
        trig_acc <= trig_acc + trig_count_t'(1);
        // Bunch crossing of the accepted trigger itself
        last_bxn <= bxn;
      end
      if (veto) begin
        trig_drop <= trig_drop + trig_count_t'(1);
      end
    end
  end

endmodule

/* hdl/ttc_cmd_decoder.sv */
// Broadcast commands are taken as already deserialized, one per valid cycle
// Unknown codes are ignored without any error indication
`timescale 1ns/100ps

module ttc_cmd_decoder (
  input  logic              clock,
  input  logic              reset,
  input  ttc_pkg::ttc_cmd_t ttc_cmd,
  input  logic              ttc_cmd_valid,
  output logic              bx0,
  output logic              resync
);

  import ttc_pkg::*;

  logic is_bx0;
  logic is_resync;

  // --------------------
  // Command match
  // --------------------

  // Only a valid command counts
  assign is_bx0    = ttc_cmd_valid && (ttc_cmd == CMD_BX0);
  assign is_resync = ttc_cmd_valid && (ttc_cmd == CMD_RESYNC);

  // --------------------
  // Strobe registers
  // --------------------

  // One cycle per command, one cycle after it arrives
  always_ff @(posedge clock) begin
    if (reset) begin
      bx0    <= 1'b0;
      resync <= 1'b0;
    end else begin
      bx0    <= is_bx0;
      resync <= is_resync;
    end
  end

endmodule

/* hdl/ttc_control_top.sv */
// Single clock domain, TTC commands arrive already deserialized
// No L1A buffering, triggers leave on trig_out the cycle after acceptance
`timescale 1ns/100ps

module ttc_control_top (
  input  logic               clock,
  input  logic               reset,
  input  logic               ttc_cmd_valid,
  input  logic               trig_in,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  ttc_pkg::ttc_cmd_t  ttc_cmd,
  input  ttc_pkg::apb_addr_t paddr,
  input  ttc_pkg::apb_data_t pwdata,
  output ttc_pkg::apb_data_t prdata,
  output logic               pslverr,
  output logic               trig_out,
  output logic               fmm_trig_stop
);

  import ttc_pkg::*;

  // TTC strobes
  logic        bx0;
  logic        resync;

  // Orbit counter
  bxn_t        bxn;
  logic        sync_err;

  // Control from the register block
  logic        ignore_startstop;
  logic        force_stop_trigger;
  logic        dont_wait;
  logic        clear_sync_err;
  bxn_t        bxn_preset;

  // Status back to the register block
  fmm_state_t  fmm_state;
  trig_count_t trig_acc;
  trig_count_t trig_drop;
  bxn_t        last_bxn;

  // --------------------
  // Blocks
  // --------------------

  ttc_cmd_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .ttc_cmd       (ttc_cmd),
    .ttc_cmd_valid (ttc_cmd_valid),
    .bx0           (bx0),
    .resync        (resync)
  );

  bx_counter u_bx_counter (
    .clock          (clock),
    .reset          (reset),
    .bx0            (bx0),
    .resync         (resync),
    .clear_sync_err (clear_sync_err),
    .bxn_preset     (bxn_preset),
    .bxn            (bxn),
    .sync_err       (sync_err)
  );

  fmm u_fmm (
    .clock              (clock),
    .reset              (reset),
    .bx0                (bx0),
    .resync             (resync),
    .ignore_startstop   (ignore_startstop),
    .force_stop_trigger (force_stop_trigger),
    .dont_wait          (dont_wait),
    .fmm_trig_stop      (fmm_trig_stop),
    .fmm_state          (fmm_state)
  );

  trigger_gate u_trigger_gate (
    .clock         (clock),
    .reset         (reset),
    .trig_in       (trig_in),
    .fmm_trig_stop (fmm_trig_stop),
    .bxn           (bxn),
    .trig_out      (trig_out),
    .trig_acc      (trig_acc),
    .trig_drop     (trig_drop),
    .last_bxn      (last_bxn)
  );

  apb_ctrl_regs u_regs (
    .clock              (clock),
    .reset              (reset),
    .psel               (psel),
    .penable            (penable),
    .pwrite             (pwrite),
    .paddr              (paddr),
    .pwdata             (pwdata),
    .prdata             (prdata),
    .pslverr            (pslverr),
    .sync_err           (sync_err),
    .fmm_trig_stop      (fmm_trig_stop),
    .fmm_state          (fmm_state),
    .bxn                (bxn),
    .last_bxn           (last_bxn),
    .trig_acc           (trig_acc),
    .trig_drop          (trig_drop),
    .ignore_startstop   (ignore_startstop),
    .force_stop_trigger (force_stop_trigger),
    .dont_wait          (dont_wait),
    .clear_sync_err     (clear_sync_err),
    .bxn_preset         (bxn_preset)
  );

endmodule

/* hdl/ttc_pkg.sv */
// Shared widths, TTC command codes, FMM states and APB register map
// Counter limits follow the LHC orbit of 3564 bunch crossings
package ttc_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int BXN_W       = 12;
  localparam int CMD_W       = 8;
  localparam int TRIG_CNT_W  = 16;
  localparam int APB_ADDR_W  = 8;
  localparam int APB_DATA_W  = 32;
  localparam int FMM_STATE_W = 3;

  typedef logic [BXN_W-1:0]      bxn_t;
  typedef logic [CMD_W-1:0]      ttc_cmd_t;
  // Trigger counters wrap silently
  typedef logic [TRIG_CNT_W-1:0] trig_count_t;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // FMM state codes as read back in STATUS
  typedef enum logic [FMM_STATE_W-1:0] {
    fmm_startup  = 3'd0,
    fmm_resync   = 3'd1,
    fmm_stop     = 3'd2,
    fmm_wait_bx0 = 3'd3,
    fmm_run      = 3'd4
  } fmm_state_t;

  // --------------------
  // Orbit and commands
  // --------------------
  localparam bxn_t BX_MAX           = 12'd3563;
  // Typical L0 latency
  localparam bxn_t BXN_PRESET_RESET = 12'd160;

  localparam ttc_cmd_t CMD_BX0    = 8'h01;
  localparam ttc_cmd_t CMD_RESYNC = 8'h04;

  // --------------------
  // APB register map
  // --------------------
  localparam apb_addr_t ADDR_CTRL      = 8'h00;
  localparam apb_addr_t ADDR_PRESET    = 8'h04;
  localparam apb_addr_t ADDR_STATUS    = 8'h08;
  localparam apb_addr_t ADDR_BXN       = 8'h0C;
  localparam apb_addr_t ADDR_TRIG_ACC  = 8'h10;
  localparam apb_addr_t ADDR_TRIG_DROP = 8'h14;
  localparam apb_addr_t ADDR_LAST_BXN  = 8'h18;

endpackage

/* test/tb_ttc_control.sv */
// Cycle model steps on each rising edge and outputs are compared at the falling edge
// Stimulus changes 1 ns after the rising edge
`timescale 1ns/100ps

module tb_ttc_control;

  import ttc_pkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 10;
  localparam int N_CMD          = 80;
  localparam int N_CTRL         = 80;
  localparam int N_TRIG         = 120;
  localparam int N_PRESET       = 8;
  // APB transfers take two cycles, a preset round about twelve
  localparam int PLANNED_CYCLES = RESET_CYCLES + 40 + 2 * (N_CMD + N_CTRL + N_TRIG)
                                  + 12 * N_PRESET + 10;

  logic        clock;
  logic        reset;
  logic        ttc_cmd_valid;
  logic        trig_in;
  logic        psel;
  logic        penable;
  logic        pwrite;
  ttc_cmd_t    ttc_cmd;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pslverr;
  logic        trig_out;
  logic        fmm_trig_stop;

  // Enables for random side stimulus
  logic        ttc_rand;
  logic        trig_rand;
  logic [31:0] lfsr_state;

  // Model state
  logic        m_bx0;
  logic        m_resync;
  bxn_t        m_bxn;
  logic        m_sync_err;
  fmm_state_t  m_state;
  logic        m_stop;
  logic        m_trig_out;
  trig_count_t m_acc;
  trig_count_t m_drop;
  bxn_t        m_last;
  logic        m_ign;
  logic        m_force;
  logic        m_dw;
  bxn_t        m_preset;

  ttc_control_top UUT (
    .clock         (clock),
    .reset         (reset),
    .ttc_cmd_valid (ttc_cmd_valid),
    .trig_in       (trig_in),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .ttc_cmd       (ttc_cmd),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pslverr       (pslverr),
    .trig_out      (trig_out),
    .fmm_trig_stop (fmm_trig_stop)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // --------------------
  // Random source
  // --------------------

  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        out_bit;
    v = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'hD000_0001;
      end
      v = {v[30:0], out_bit};
    end
    return v;
  endfunction

  // --------------------
  // Error handling
  // --------------------

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bxn(input string name, input bxn_t got, input bxn_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input trig_count_t got,
                             input trig_count_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // --------------------
  // Model
  // --------------------

  function automatic logic is_mapped(input apb_addr_t addr);
    return addr inside {ADDR_CTRL, ADDR_PRESET, ADDR_STATUS, ADDR_BXN,
                        ADDR_TRIG_ACC, ADDR_TRIG_DROP, ADDR_LAST_BXN};
  endfunction

  function automatic logic is_writable(input apb_addr_t addr);
    return (addr == ADDR_CTRL) || (addr == ADDR_PRESET);
  endfunction

  function automatic apb_data_t model_read(input apb_addr_t addr);
    apb_data_t d;
    d = '0;
    case (addr)
      ADDR_CTRL:      d[2:0] = {m_dw, m_force, m_ign};
      ADDR_PRESET:    d[11:0] = m_preset;
      ADDR_STATUS: begin
        d[0]   = m_sync_err;
        d[1]   = m_stop;
        d[6:4] = m_state;
      end
      ADDR_BXN:       d[11:0] = m_bxn;
      ADDR_TRIG_ACC:  d[15:0] = m_acc;
      ADDR_TRIG_DROP: d[15:0] = m_drop;
      ADDR_LAST_BXN:  d[11:0] = m_last;
      default:        d = '0;
    endcase
    return d;
  endfunction

  function automatic fmm_state_t fmm_next(input fmm_state_t s, input logic b0,
                                          input logic rs, input logic stop_req,
                                          input logic dw);
    fmm_state_t n;
    n = s;
    if (rs) begin
      n = fmm_resync;
    end else begin
      case (s)
        fmm_startup:  n = fmm_stop;
        fmm_resync:   n = b0 ? fmm_run : fmm_wait_bx0;
        fmm_stop:     n = stop_req ? fmm_stop : fmm_wait_bx0;
        fmm_wait_bx0: begin
          if (b0 || dw) begin
            n = fmm_run;
          end else if (stop_req) begin
            n = fmm_stop;
          end
        end
        fmm_run:      n = stop_req ? fmm_stop : fmm_run;
        default:      n = fmm_stop;
      endcase
    end
    return n;
  endfunction

  task automatic model_reset();
    m_bx0      = 1'b0;
    m_resync   = 1'b0;
    m_bxn      = '0;
    m_sync_err = 1'b0;
    m_state    = fmm_startup;
    m_stop     = 1'b1;
    m_trig_out = 1'b0;
    m_acc      = '0;
    m_drop     = '0;
    m_last     = '0;
    m_ign      = 1'b0;
    m_force    = 1'b0;
    m_dw       = 1'b0;
    m_preset   = BXN_PRESET_RESET;
  endtask

  // Every update reads the values from before the edge
  task automatic model_step();
    logic wr;
    logic clr;
    logic stop_req;
    wr       = psel && penable && pwrite;
    clr      = wr && (paddr == ADDR_CTRL) && pwdata[3];
    stop_req = m_force && !m_ign;
    // Trigger gate
    m_trig_out = trig_in && !m_stop;
    if (trig_in && !m_stop) begin
      m_acc  = m_acc + 1'b1;
      m_last = m_bxn;
    end
    if (trig_in && m_stop) begin
      m_drop = m_drop + 1'b1;
    end
    // FMM stop flag sees the old state
    m_stop  = (m_state != fmm_run);
    m_state = fmm_next(m_state, m_bx0, m_resync, stop_req, m_dw);
    // Sticky alignment error where clear wins
    if (clr) begin
      m_sync_err = 1'b0;
    end else if (m_bx0 && (m_bxn != m_preset)) begin
      m_sync_err = 1'b1;
    end
    // Orbit counter
    if (m_resync) begin
      m_bxn = m_preset;
    end else if (m_bxn == BX_MAX) begin
      m_bxn = '0;
    end else begin
      m_bxn = m_bxn + 1'b1;
    end
    // Decoder strobes
    m_bx0    = ttc_cmd_valid && (ttc_cmd == CMD_BX0);
    m_resync = ttc_cmd_valid && (ttc_cmd == CMD_RESYNC);
    // Writable registers
    if (wr && (paddr == ADDR_CTRL)) begin
      m_ign   = pwdata[0];
      m_force = pwdata[1];
      m_dw    = pwdata[2];
    end
    if (wr && (paddr == ADDR_PRESET)) begin
      m_preset = pwdata[11:0];
    end
  endtask

  // --------------------
  // Cycle engine
  // --------------------

  task automatic check_outputs();
    logic access;
    logic exp_err;
    access  = psel && penable;
    exp_err = access && (!is_mapped(paddr) || (pwrite && !is_writable(paddr)));
    check_bit("trig_out", trig_out, m_trig_out);
    check_bit("fmm_trig_stop", fmm_trig_stop, m_stop);
    check_bit("pslverr", pslverr, exp_err);
    if (access && !pwrite) begin
      case (paddr)
        ADDR_PRESET:    check_bxn("bxn_preset", bxn_t'(prdata), m_preset);
        ADDR_BXN:       check_bxn("bxn", bxn_t'(prdata), m_bxn);
        ADDR_LAST_BXN:  check_bxn("last_bxn", bxn_t'(prdata), m_last);
        ADDR_TRIG_ACC:  check_count("trig_acc", trig_count_t'(prdata), m_acc);
        ADDR_TRIG_DROP: check_count("trig_drop", trig_count_t'(prdata), m_drop);
        default:        ;
      endcase
      check_data("prdata", prdata, model_read(paddr));
    end
  endtask

  task automatic pick_ttc();
    logic [31:0] r;
    r             = rand_bits(5);
    ttc_cmd       = ttc_cmd_t'(rand_bits(8));
    ttc_cmd_valid = 1'b0;
    case (r[4:0])
      5'd0: begin
        ttc_cmd_valid = 1'b1;
        ttc_cmd       = CMD_BX0;
      end
      5'd1: begin
        ttc_cmd_valid = 1'b1;
        ttc_cmd       = CMD_RESYNC;
      end
      // Random code with valid set
      5'd2, 5'd3: ttc_cmd_valid = 1'b1;
      // Known code without valid
      5'd4:       ttc_cmd = CMD_BX0;
      default:    ;
    endcase
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic tick();
    if (ttc_rand) begin
      pick_ttc();
    end
    if (trig_rand) begin
      trig_in = (rand_bits(1) != '0);
    end
    @(negedge clock);
    check_outputs();
    @(posedge clock);
    model_step();
    #1;
  endtask

  task automatic send_cmd(input ttc_cmd_t cmd);
    ttc_cmd_valid = 1'b1;
    ttc_cmd       = cmd;
    tick();
    ttc_cmd_valid = 1'b0;
  endtask

  // Setup cycle then access cycle
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    tick();
    penable = 1'b1;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // --------------------
  // Watchdog
  // --------------------

  initial begin
    #(PLANNED_CYCLES * CLK_PERIOD + 200);
    $display("Timeout: the run did not finish in the planned time");
    abort_run();
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    logic [31:0] r;
    apb_data_t   pw;
    reset         = 1'b1;
    ttc_cmd_valid = 1'b0;
    ttc_cmd       = '0;
    trig_in       = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    ttc_rand      = 1'b0;
    trig_rand     = 1'b0;
    lfsr_state    = 32'h4485_7838;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;

    // Startup holds triggers until bx0, then dont_wait after a resync
    repeat (8) tick();
    check_bit("fmm_trig_stop", fmm_trig_stop, 1'b1);
    send_cmd(CMD_BX0);
    repeat (4) tick();
    check_bit("fmm_trig_stop", fmm_trig_stop, 1'b0);
    send_cmd(CMD_RESYNC);
    repeat (2) tick();
    apb_xfer(1'b1, ADDR_CTRL, 32'hC);
    // Clear bit reads back as 0
    apb_xfer(1'b0, ADDR_CTRL, '0);
    repeat (3) tick();
    check_bit("fmm_trig_stop", fmm_trig_stop, 1'b0);
    apb_xfer(1'b1, ADDR_CTRL, 32'h0);

    // Random commands, status reads and error clears
    ttc_rand = 1'b1;
    for (int i = 0; i < N_CMD; i++) begin
      r = rand_bits(3);
      case (r[1:0])
        2'd0: apb_xfer(1'b0, ADDR_STATUS, '0);
        2'd1: apb_xfer(1'b0, ADDR_BXN, '0);
        2'd2: apb_xfer(1'b1, ADDR_CTRL, {28'd0, r[2], 3'b000});
        default: tick();
      endcase
    end

    // Random control writes with status reads
    for (int i = 0; i < N_CTRL; i++) begin
      r = rand_bits(5);
      if (r[0]) begin
        apb_xfer(1'b1, ADDR_CTRL, {28'd0, r[4:1]});
      end else begin
        apb_xfer(1'b0, ADDR_STATUS, '0);
      end
    end

    // Random triggers, counter and latch reads
    trig_rand = 1'b1;
    for (int i = 0; i < N_TRIG; i++) begin
      r = rand_bits(6);
      case (r[2:0])
        3'd0: apb_xfer(1'b0, ADDR_TRIG_ACC, '0);
        3'd1: apb_xfer(1'b0, ADDR_TRIG_DROP, '0);
        3'd2: apb_xfer(1'b0, ADDR_LAST_BXN, '0);
        3'd3: apb_xfer(1'b1, ADDR_CTRL, {29'd0, r[5:3]});
        3'd4: apb_xfer(1'b0, ADDR_STATUS, '0);
        default: tick();
      endcase
    end

    // Preset load, read-only writes and unmapped addresses
    ttc_rand      = 1'b0;
    trig_rand     = 1'b0;
    ttc_cmd_valid = 1'b0;
    trig_in       = 1'b0;
    for (int i = 0; i < N_PRESET; i++) begin
      pw        = rand_bits(32);
      pw[11:0]  = bxn_t'(rand_bits(12) % (int'(BX_MAX) + 1));
      apb_xfer(1'b1, ADDR_PRESET, pw);
      apb_xfer(1'b0, ADDR_PRESET, '0);
      send_cmd(CMD_RESYNC);
      tick();
      apb_xfer(1'b0, ADDR_BXN, '0);
      r = rand_bits(3);
      apb_xfer(1'b1, apb_addr_t'(ADDR_STATUS + 4 * (r % 5)), rand_bits(32));
      r = rand_bits(9);
      // Mapped addresses are word aligned
      if (is_mapped(r[7:0])) begin
        r[0] = 1'b1;
      end
      apb_xfer(r[8], r[7:0], rand_bits(32));
    end
    repeat (2) tick();

    if (UUT.u_asserts.fail_count != 0) begin
      $display("Bound assertions reported %0d failures", UUT.u_asserts.fail_count);
      abort_run();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* test/ttc_control_asserts.sv */
// Bound into ttc_control_top to check strobes, orbit range and trigger stop
// Every failed assertion also increments fail_count
`timescale 1ns/100ps

module ttc_control_asserts (
  input logic              clock,
  input logic              reset,
  input ttc_pkg::ttc_cmd_t ttc_cmd,
  input logic              ttc_cmd_valid,
  input logic              bx0,
  input logic              resync,
  input ttc_pkg::bxn_t     bxn,
  input logic              trig_out,
  input logic              fmm_trig_stop
);

  import ttc_pkg::*;

  int unsigned fail_count = 0;

  // --------------------
  // TTC strobes
  // --------------------

  // A strobe only follows its own valid command
  bx0_follows_cmd: assert property (@(posedge clock) disable iff (reset)
    bx0 |-> ($past(ttc_cmd_valid) && ($past(ttc_cmd) == CMD_BX0)))
    else begin
      fail_count++;
      $error("bx0 strobe without a bx0 command in the cycle before");
    end

  resync_follows_cmd: assert property (@(posedge clock) disable iff (reset)
    resync |-> ($past(ttc_cmd_valid) && ($past(ttc_cmd) == CMD_RESYNC)))
    else begin
      fail_count++;
      $error("resync strobe without a resync command in the cycle before");
    end

  // --------------------
  // Counter and gate
  // --------------------

  bxn_in_range: assert property (@(posedge clock) disable iff (reset)
    bxn <= BX_MAX)
    else begin
      fail_count++;
      $error("bunch crossing count above the last orbit count");
    end

  // Accepted trigger needs an open gate one cycle earlier
  trig_needs_open_gate: assert property (@(posedge clock) disable iff (reset)
    trig_out |-> !$past(fmm_trig_stop))
    else begin
      fail_count++;
      $error("trigger passed while the stop flag was set");
    end

  stop_in_reset: assert property (@(posedge clock)
    reset |=> fmm_trig_stop)
    else begin
      fail_count++;
      $error("trigger stop low while reset was applied");
    end

endmodule

bind ttc_control_top ttc_control_asserts u_asserts (
  .clock         (clock),
  .reset         (reset),
  .ttc_cmd       (ttc_cmd),
  .ttc_cmd_valid (ttc_cmd_valid),
  .bx0           (bx0),
  .resync        (resync),
  .bxn           (bxn),
  .trig_out      (trig_out),
  .fmm_trig_stop (fmm_trig_stop)
);
